//--- hw/seg_pkg.sv
// seven-segment scan display shared types
// digit values, active-low segment patterns, digit positions and anode enables
package seg_pkg;

	// display geometry
	localparam int NUM_SEGMENTS = 7; // segments a to g, no decimal point
	localparam int NUM_DIGITS   = 4; // four common-anode digits

	// one hex value as written by the host
	typedef logic [3:0] hex_digit_t; // 0 to f

	// segment pattern, active low
	// bit 6 is segment a, bit 0 is segment g
	// a 0 lights the segment
	typedef logic [NUM_SEGMENTS-1:0] seg_pattern_t;

	// digit position, 0 is the least significant digit
	typedef logic [$clog2(NUM_DIGITS)-1:0] digit_index_t;

	// anode enables, active high, one bit per digit position
	typedef logic [NUM_DIGITS-1:0] anode_t;

	// pattern with every segment dark
	localparam seg_pattern_t BLANK_PATTERN = '1;

	// segment bit positions inside seg_pattern_t
	//   a = 6   top bar
	//   b = 5   upper right
	//   c = 4   lower right
	//   d = 3   bottom bar
	//   e = 2   lower left
	//   f = 1   upper left
	//   g = 0   middle bar
	//
	//      aaa
	//     f   b
	//     f   b
	//      ggg
	//     e   c
	//     e   c
	//      ddd
	//
	// the scan token walks a, b, c ... g and wraps back to a
	// the digit scan walks position 0, 1, 2, 3 and wraps

endpackage

//--- hw/scan_if.sv
// scan bus between timebase, digit mux and segment scanner
// carries the two scan enables, the current digit and its latched pattern
`timescale 1ns/1ps

interface scan_if;
	import seg_pkg::*;

	logic         dot_tick;       // one cycle per segment step
	logic         digit_tick;     // one cycle per digit window, lands on a dot_tick
	digit_index_t digit_index;    // digit to show next, valid with digit_tick
	seg_pattern_t active_pattern; // pattern of the digit currently lit

	// free-running counter side
	modport timebase (
		output dot_tick,
		output digit_tick,
		output digit_index
	);

	// anode driver picks up the digit and latches its pattern
	modport mux (
		input  digit_tick,
		input  digit_index,
		output active_pattern
	);

	// segment token walks the latched pattern
	modport scanner (
		input  dot_tick,
		input  active_pattern
	);

endinterface

//--- hw/scan_timebase.sv
// scan timebase, one free-running counter for both scan rates
// decodes single-cycle segment and digit enables plus the digit index
`timescale 1ns/1ps

module scan_timebase #(
	parameter int DOT_SHIFT   = 3, // segment tick every 2**DOT_SHIFT cycles
	parameter int DIGIT_SHIFT = 4  // digit tick every 2**DIGIT_SHIFT segment ticks
) (
	input  logic       CLK,
	input  logic       reset,
	scan_if.timebase   tb
);
	import seg_pkg::*;

	// counter layout, lsb first
	//   [DOT_SHIFT-1:0]          cycles inside one segment step
	//   [DIGIT_LSB-1:DOT_SHIFT]  segment steps inside one digit window
	//   [CNT_W-1:DIGIT_LSB]      digit index
	localparam int DIGIT_LSB = DOT_SHIFT + DIGIT_SHIFT;
	localparam int CNT_W     = DIGIT_LSB + $bits(digit_index_t);

	logic [CNT_W-1:0] count; // free-running, wraps after a full scan

	always_ff @(posedge CLK) begin
		if (reset) begin
			count <= '0;
		end else begin
			count <= count + 1'b1; // counts every cycle, no enable
		end
	end

	// enables fire when the fields below them roll over to zero
	always_comb begin
		tb.dot_tick   = (count[DOT_SHIFT-1:0] == '0);
		tb.digit_tick = (count[DIGIT_LSB-1:0] == '0); // implies dot_tick
	end

	// index bits step on the same carry that raises digit_tick
	assign tb.digit_index = count[CNT_W-1:DIGIT_LSB];

endmodule

//--- hw/digit_shift_store.sv
// digit store for the scan display
// decodes each written hex value to segments and shifts it in at digit 0
`timescale 1ns/1ps

module digit_shift_store (
	input  logic                                            CLK,
	input  logic                                            reset,
	input  logic                                            digit_valid,
	input  seg_pkg::hex_digit_t                             digit_value,
	output seg_pkg::seg_pattern_t [seg_pkg::NUM_DIGITS-1:0] patterns
);
	import seg_pkg::*;

	seg_pattern_t new_pattern; // decoded form of digit_value

	// hex to active-low segments, bit order a b c d e f g
	function automatic seg_pattern_t decode_hex(input hex_digit_t value);
		seg_pattern_t pat;
		case (value)
			4'h0:    pat = 7'b0000001;
			4'h1:    pat = 7'b1001111; // b c
			4'h2:    pat = 7'b0010010;
			4'h3:    pat = 7'b0000110;
			4'h4:    pat = 7'b1001100; // b c f g
			4'h5:    pat = 7'b0100100;
			4'h6:    pat = 7'b0100000;
			4'h7:    pat = 7'b0001111; // a b c
			4'h8:    pat = 7'b0000000; // everything on
			4'h9:    pat = 7'b0000100;
			4'ha:    pat = 7'b0001000; // A
			4'hb:    pat = 7'b1100000; // lower-case b
			4'hc:    pat = 7'b0110001; // C, a d e f
			4'hd:    pat = 7'b1000010; // lower-case d
			4'he:    pat = 7'b0110000; // E
			default: pat = 7'b0111000; // F
		endcase
		return pat;
	endfunction

	// decode ahead of the register so the store holds segment patterns only
	always_comb begin
		new_pattern = decode_hex(digit_value);
	end

	// shift register, position 0 is the least significant digit
	// a write pushes everything one place toward the msd
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < NUM_DIGITS; i++) begin
				patterns[i] <= BLANK_PATTERN; // display starts dark
			end
		end else if (digit_valid) begin
			for (int i = NUM_DIGITS - 1; i > 0; i--) begin
				patterns[i] <= patterns[i-1]; // old msd falls off the end
			end
			patterns[0] <= new_pattern; // newest digit on the right
		end
	end

	// no ready, a write is taken on every cycle digit_valid is high
	// back-to-back writes shift once per cycle
	// the pattern is visible on patterns one cycle after the write edge
	//
	// patterns[3] is the leftmost digit on the board
	// patterns[0] is the rightmost digit on the board
	//
	// the mux reads this array only on its own digit tick
	// so a write in mid window shows up on the next visit to that digit
	// and the digit being lit never changes pattern half way through
	//
	// nothing here depends on the scan rate

endmodule

//--- hw/digit_mux.sv
// anode driver for the scan display
// lights one digit per digit window and latches that digit's pattern
`timescale 1ns/1ps

module digit_mux (
	input  logic                                            CLK,
	input  logic                                            reset,
	input  seg_pkg::seg_pattern_t [seg_pkg::NUM_DIGITS-1:0] patterns,
	scan_if.mux                                             sc,
	output seg_pkg::anode_t                                 anodes
);
	import seg_pkg::*;

	anode_t next_anodes; // one-hot enable for the incoming digit

	// the incoming digit takes the only anode
	// the old one drops in the same edge, so no two digits overlap
	always_comb begin
		next_anodes = '0;
		next_anodes[sc.digit_index] = 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			anodes <= '0; // all digits off until the first window
		end else if (sc.digit_tick) begin
			anodes <= next_anodes;
		end
	end

	// pattern is frozen for the whole window
	// host writes during the window wait for the next visit
	always_ff @(posedge CLK) begin
		if (reset) begin
			sc.active_pattern <= BLANK_PATTERN; // scanner sees a dark digit
		end else if (sc.digit_tick) begin
			sc.active_pattern <= patterns[sc.digit_index];
		end
	end

	// anodes and active_pattern move on the same edge
	// the segment still lit from the last window belongs to the old digit
	// and is cleared by the scanner on its next step
	//
	// window order follows digit_index, 0 1 2 3 and wrap
	// with a window of at least seven segment ticks every segment
	// of the digit gets its turn before the anode moves on
	//
	// the anode stays on for the whole window, so the board sees
	// a short dark gap only where the segment token is on an unlit segment
	//
	// anodes are common anode enables, active high here
	// any board inversion belongs outside this block

endmodule

//--- hw/segment_scanner.sv
// segment scanner for the scan display
// a one-hot token walks segments a to g and lights one segment at a time
`timescale 1ns/1ps

module segment_scanner (
	input  logic                  CLK,
	input  logic                  reset,
	scan_if.scanner               sc,
	output seg_pkg::seg_pattern_t segments
);
	import seg_pkg::*;

	// token bit i matches segment bit i of seg_pattern_t
	// bit 6 is segment a, so the token starts at the top and shifts down
	localparam seg_pattern_t TOKEN_AT_A = seg_pattern_t'(1) << (NUM_SEGMENTS - 1);

	logic [NUM_SEGMENTS-1:0] token;      // segment that takes its value next
	logic [NUM_SEGMENTS-1:0] prev_token; // segment the token just left
	logic [NUM_SEGMENTS-1:0] next_token; // token after this step

	// rotate toward g, g wraps back to a
	always_comb begin
		next_token = {token[0], token[NUM_SEGMENTS-1:1]};
	end

	// one place behind the token, for a that is g
	always_comb begin
		prev_token = {token[NUM_SEGMENTS-2:0], token[NUM_SEGMENTS-1]};
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			token <= TOKEN_AT_A;
		end else if (sc.dot_tick) begin
			token <= next_token;
		end
	end

	// per step the segment under the token follows the pattern
	// and the segment behind it is forced dark
	// every other segment already went dark on an earlier step
	always_ff @(posedge CLK) begin
		if (reset) begin
			segments <= BLANK_PATTERN; // all segments off
		end else if (sc.dot_tick) begin
			for (int i = 0; i < NUM_SEGMENTS; i++) begin
				if (token[i]) begin
					segments[i] <= sc.active_pattern[i]; // light if pattern says so
				end else if (prev_token[i]) begin
					segments[i] <= 1'b1; // switch off the one before
				end
			end
		end
	end

	// result is a single lit segment at most, which keeps the
	// current per digit flat no matter how many segments the digit uses
	//
	// the token is not resynced to the digit window
	// each window holds seven or more steps, so every segment gets a turn
	// the first lit segment after an anode change still shows the old digit
	// until the token passes the next segment
	//
	// dot_tick also lands on each digit_tick, so the step on the anode
	// change edge still uses the old active_pattern

endmodule

//--- hw/seven_seg_scan_top.sv
// four-digit common-anode seven-segment scan display
// host shifts in hex digits, display is scanned one digit and one segment at a time
`timescale 1ns/1ps

module seven_seg_scan_top #(
	parameter int DOT_SHIFT   = 3, // segment step every 2**DOT_SHIFT cycles
	parameter int DIGIT_SHIFT = 4  // digit window of 2**DIGIT_SHIFT steps, 3 or more
) (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic                  digit_valid, // one-cycle write strobe
	input  seg_pkg::hex_digit_t   digit_value, // hex value, enters at digit 0
	output seg_pkg::seg_pattern_t segments,    // active low, bit 6 is segment a
	output seg_pkg::anode_t       anodes       // active high, bit 0 is the lsd
);
	import seg_pkg::*;

	// decoded digits, position 0 is the least significant digit
	seg_pattern_t [NUM_DIGITS-1:0] patterns;

	// ticks, digit index and the latched pattern
	scan_if i_scan_if ();

	// counter and enable decode
	scan_timebase #(
		.DOT_SHIFT   (DOT_SHIFT),
		.DIGIT_SHIFT (DIGIT_SHIFT)
	) i_scan_timebase (
		.CLK   (CLK),
		.reset (reset),
		.tb    (i_scan_if.timebase)
	);

	// host write side
	digit_shift_store i_digit_shift_store (
		.CLK         (CLK),
		.reset       (reset),
		.digit_valid (digit_valid),
		.digit_value (digit_value),
		.patterns    (patterns)
	);

	// one anode per window, latches that digit's pattern
	digit_mux i_digit_mux (
		.CLK      (CLK),
		.reset    (reset),
		.patterns (patterns),
		.sc       (i_scan_if.mux),
		.anodes   (anodes)
	);

	// one segment lit at a time from the latched pattern
	segment_scanner i_segment_scanner (
		.CLK      (CLK),
		.reset    (reset),
		.sc       (i_scan_if.scanner),
		.segments (segments)
	);

	// write to visible segment latency
	//   one cycle into the store
	//   then up to a full scan of four windows before the mux visits that digit
	//   then the token has to reach the segment
	//
	// there is no back-pressure, every strobe is taken
	//
	// with the defaults a segment step is 8 cycles and a window 128 cycles
	// so one full scan of the display is 512 cycles
	//
	// anodes and segments come straight from registers
	// no output logic sits between the flops and the pins

endmodule

//--- tests/tb_seg_checks.svh
// testbench checks for the seven-segment scan display
// reference decoder, typed compare tasks and anode waits with timeouts
`ifndef TB_SEG_CHECKS_SVH
`define TB_SEG_CHECKS_SVH

// lit segments listed active high, a in bit 6, then inverted for the board
function automatic seg_pattern_t expected_pattern(input hex_digit_t value);
	logic [6:0] lit; // 1 means segment on
	case (value)
		4'h0:    lit = 7'b1111110; // a b c d e f
		4'h1:    lit = 7'b0110000; // b c
		4'h2:    lit = 7'b1101101; // a b d e g
		4'h3:    lit = 7'b1111001; // a b c d g
		4'h4:    lit = 7'b0110011; // b c f g
		4'h5:    lit = 7'b1011011; // a c d f g
		4'h6:    lit = 7'b1011111; // a c d e f g
		4'h7:    lit = 7'b1110000; // a b c
		4'h8:    lit = 7'b1111111;
		4'h9:    lit = 7'b1111011; // a b c d f g
		4'ha:    lit = 7'b1110111; // a b c e f g
		4'hb:    lit = 7'b0011111; // c d e f g
		4'hc:    lit = 7'b1001110; // a d e f
		4'hd:    lit = 7'b0111101; // b c d e g
		4'he:    lit = 7'b1001111; // a d e f g
		default: lit = 7'b1000111; // a e f g
	endcase
	return ~lit;
endfunction

task automatic check_pattern(input string name, input seg_pattern_t actual,
		input seg_pattern_t expected);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
	end
endtask

task automatic check_anodes(input string name, input anode_t actual, input anode_t expected);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
	end
endtask

// a missing anode change counts against the anode order test
task automatic report_timeout(input string what, input int cycles);
	error_count++;
	anode_errors++;
	$display("Timeout at %0t ns: %s did not happen within %0d cycles", $time, what, cycles);
endtask

task automatic wait_anode_change();
	anode_t start; // value seen when the wait began
	int     n;
	start = anodes;
	n     = 0;
	while (anodes === start && n < ANODE_TIMEOUT) begin
		@(negedge CLK);
		n++;
	end
	if (anodes === start) begin
		report_timeout("anode change", ANODE_TIMEOUT);
	end
endtask

task automatic wait_anode_position(input digit_index_t pos);
	anode_t target; // one-hot for pos
	int     n;
	target = anode_t'(1) << pos;
	n      = 0;
	while (anodes !== target && n < SCAN_TIMEOUT) begin
		@(negedge CLK);
		n++;
	end
	if (anodes !== target) begin
		report_timeout($sformatf("anode %0d switching on", pos), SCAN_TIMEOUT);
	end
endtask

// five changes, so four whole windows start after the call
task automatic wait_full_scan();
	for (int i = 0; i <= NUM_DIGITS; i++) begin
		wait_anode_change();
	end
	@(posedge CLK); // monitor has stored the last window by now
endtask

`endif

//--- tests/tb_seven_seg_scan.sv
// testbench for the four-digit seven-segment scan display
// writes hex digits, watches the anode and segment scan, compares every digit window
`timescale 1ns/1ps

module tb_seven_seg_scan;
	import seg_pkg::*;

	localparam int DOT_SHIFT     = 2;
	localparam int DIGIT_SHIFT   = 4;
	localparam int CLK_HALF      = 4;                              // 8 ns clock
	localparam int NUM_RESET     = 10;                             // reset cycles
	localparam int DOT_CYCLES    = 1 << DOT_SHIFT;                 // cycles per segment step
	localparam int WINDOW_CYCLES = 1 << (DOT_SHIFT + DIGIT_SHIFT); // cycles per digit window
	localparam int ANODE_TIMEOUT = 2 * WINDOW_CYCLES;
	localparam int SCAN_TIMEOUT  = (NUM_DIGITS + 1) * WINDOW_CYCLES;

	logic         CLK;
	logic         reset;
	logic         digit_valid;
	hex_digit_t   digit_value;
	seg_pattern_t segments;
	anode_t       anodes;

	int error_count  = 0; // every failed check
	int check_count  = 0;
	int anode_errors = 0; // order, one-hot and timeouts
	int seg_errors   = 0; // more than one segment lit
	int tests_run    = 0;
	int tests_failed = 0;

	integer     seed;
	hex_digit_t model_q[$];                   // index 0 is the newest digit
	seg_pattern_t window_pattern[NUM_DIGITS]; // AND of segments per last window

	// monitor state
	anode_t       last_anodes;
	digit_index_t win_pos;
	seg_pattern_t win_and;
	bit           win_open;
	int           skip_left;

	`include "tb_seg_checks.svh"

	seven_seg_scan_top #(
		.DOT_SHIFT   (DOT_SHIFT),
		.DIGIT_SHIFT (DIGIT_SHIFT)
	) i_seven_seg_scan_top (
		.CLK         (CLK),
		.reset       (reset),
		.digit_valid (digit_valid),
		.digit_value (digit_value),
		.segments    (segments),
		.anodes      (anodes)
	);

	initial begin
		CLK = 1'b0;
		forever #CLK_HALF CLK = ~CLK;
	end

	function automatic int count_lit(input seg_pattern_t s);
		int n;
		n = 0;
		for (int i = 0; i < NUM_SEGMENTS; i++) begin
			n += (s[i] == 1'b0); // active low
		end
		return n;
	endfunction

	function automatic int count_on(input anode_t a);
		int n;
		n = 0;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			n += a[i];
		end
		return n;
	endfunction

	function automatic digit_index_t lit_position(input anode_t a);
		digit_index_t pos;
		pos = '0;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			if (a[i]) pos = digit_index_t'(i);
		end
		return pos;
	endfunction

	// errors from the directed checks, without the monitor's share
	function automatic int own_errors();
		return error_count - anode_errors - seg_errors;
	endfunction

	// scan monitor, sampled mid cycle
	always @(negedge CLK) begin
		anode_t exp_anodes;
		if (reset) begin
			last_anodes = '0;
			win_open    = 1'b0;
			skip_left   = 0;
			win_and     = BLANK_PATTERN;
		end else begin
			if (count_lit(segments) > 1) begin
				error_count++;
				seg_errors++;
				$display("At %0t ns segments %b light more than one segment", $time, segments);
			end
			if (count_on(anodes) > 1) begin
				error_count++;
				anode_errors++;
				$display("At %0t ns anodes %b switch on more than one digit", $time, anodes);
			end
			if (anodes !== last_anodes) begin
				if (win_open) window_pattern[win_pos] = win_and; // window just ended
				if (anodes !== '0) begin
					exp_anodes = (last_anodes == '0) ? anode_t'(1)
						: {last_anodes[NUM_DIGITS-2:0], last_anodes[NUM_DIGITS-1]};
					if (anodes !== exp_anodes) anode_errors++;
					check_anodes("anodes", anodes, exp_anodes); // 0 1 2 3 and wrap
					win_pos   = lit_position(anodes);
					win_open  = 1'b1;
					win_and   = BLANK_PATTERN;
					skip_left = DOT_CYCLES - 1; // old digit still on for one step
				end else begin
					win_open = 1'b0;
				end
				last_anodes = anodes;
			end else if (win_open) begin
				if (skip_left > 0) skip_left--;
				else win_and &= segments;
			end
		end
	end

	task automatic apply_reset();
		int n;
		reset       = 1'b1;
		digit_valid = 1'b0;
		model_q.delete(); // store goes blank
		repeat (NUM_RESET - 1) begin
			@(posedge CLK);
			@(negedge CLK);
			check_anodes("anodes", anodes, '0);
			check_pattern("segments", segments, BLANK_PATTERN);
		end
		@(posedge CLK);
		#1;
		reset = 1'b0; // last reset edge was the one above
		n     = 0;
		do begin
			@(negedge CLK);
			n++;
			check_pattern("segments", segments, BLANK_PATTERN); // dark up to first change
		end while (anodes === '0 && n < ANODE_TIMEOUT);
		if (anodes === '0) report_timeout("first anode after reset", ANODE_TIMEOUT);
	endtask

	task automatic push_model(input hex_digit_t value);
		model_q.push_front(value);
		if (model_q.size() > NUM_DIGITS) void'(model_q.pop_back()); // oldest falls off
	endtask

	task automatic write_digit(input hex_digit_t value);
		@(posedge CLK);
		#1;
		digit_valid = 1'b1;
		digit_value = value;
		push_model(value);
		@(posedge CLK);
		#1;
		digit_valid = 1'b0;
	endtask

	// valid stays high, one new random digit per cycle
	task automatic write_burst(input int count);
		integer rnd;
		for (int i = 0; i < count; i++) begin
			@(posedge CLK);
			#1;
			rnd         = $random(seed);
			digit_valid = 1'b1;
			digit_value = rnd[3:0];
			push_model(rnd[3:0]);
		end
		@(posedge CLK);
		#1;
		digit_valid = 1'b0;
	endtask

	task automatic compare_display();
		seg_pattern_t exp;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			exp = (i < model_q.size()) ? expected_pattern(model_q[i]) : BLANK_PATTERN;
			check_pattern($sformatf("segments in digit %0d window", i), window_pattern[i], exp);
		end
	endtask

	task automatic report_test(input string name, input int errs);
		tests_run++;
		if (errs == 0) begin
			$display("test %-16s ok", name);
		end else begin
			tests_failed++;
			$display("test %-16s failed with %0d errors", name, errs);
		end
	endtask

	initial begin
		int e0;
		reset       = 1'b1;
		digit_valid = 1'b0;
		digit_value = '0;
		seed        = 37;

		e0 = own_errors();
		apply_reset();
		report_test("reset state", own_errors() - e0);

		e0 = own_errors();
		for (int base = 0; base < 16; base += NUM_DIGITS) begin
			for (int k = 0; k < NUM_DIGITS; k++) begin
				write_digit(hex_digit_t'(base + k));
			end
			wait_full_scan();
			compare_display();
		end
		report_test("hex sweep", own_errors() - e0);

		e0 = own_errors();
		write_burst(5); // first of the five must drop out
		wait_full_scan();
		compare_display();
		report_test("burst write", own_errors() - e0);

		e0 = own_errors();
		wait_anode_position(2); // somewhere mid scan
		repeat (WINDOW_CYCLES / 3) @(posedge CLK);
		#1;
		apply_reset();
		wait_full_scan();
		compare_display(); // model is empty so every window reads blank
		report_test("mid-scan reset", own_errors() - e0);

		report_test("anode order", anode_errors);
		report_test("single segment", seg_errors);

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_count, error_count);
		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- build.f
+incdir+tests
hw/seg_pkg.sv
hw/scan_if.sv
hw/scan_timebase.sv
hw/digit_shift_store.sv
hw/digit_mux.sv
hw/segment_scanner.sv
hw/seven_seg_scan_top.sv
tests/tb_seven_seg_scan.sv
